// ==== dv/decodeInput.txt ====
// fetchWord(slot1 slot0) mask stall | slot0: rt ra rb mul pair | slot1: rt ra rb mul pair
// Columns of a masked-out slot are zero, a mask of ff ends the list
// Both slots, add and subtract under each width form
0a30a20408184085 3 0 01 02 03 0 0 04 05 06 0 0
0a61650208490383 3 0 07 08 09 0 0 0a 0b 0c 0 0
0884000409efdf85 3 0 3f 3e 3d 0 0 00 20 10 0 0
091c50820ab2aa03 3 0 14 15 16 0 0 21 22 23 0 0
// Wide multiplies need the ALU pair
2430a20324184082 3 0 01 02 03 1 1 04 05 06 1 1
2469858524512404 3 0 08 09 0a 1 1 0b 0c 0d 1 1
269a48832681e702 3 0 0e 0f 10 1 1 11 12 13 1 1
2755340526d32c04 3 0 18 19 1a 1 1 28 29 2a 1 1
// Narrow multiplies and multiplies under the no-op
2238c28220206105 3 0 02 03 04 1 0 05 06 07 1 0
2059448423a67903 3 0 32 33 34 1 0 09 0a 0b 1 0
2040e30024288180 3 0 03 04 05 0 0 06 07 08 0 0
// Partial masks, last one carries an unknown opcode
0a30a2042471a605 1 0 0c 0d 0e 1 1 00 00 00 0 0
2303ef0424184082 2 0 00 00 00 0 0 1e 1f 20 1 0
0818408508184085 0 0 00 00 00 0 0 00 00 00 0 0
260820ff00000000 2 0 00 00 00 0 0 01 01 01 0 0
// Stall then keep fetching until the queue is full
0a38a18308308102 3 1 02 04 06 0 0 03 05 07 0 0
238e17842575b605 3 0 2c 2d 2e 1 1 2f 30 31 1 0
27d73c0209beda83 3 0 35 36 37 0 0 38 39 3a 1 1
21f800050a079d84 3 0 3b 3c 00 0 0 00 00 3f 1 0
24dd73830b34b202 3 0 24 25 26 0 0 27 2b 1b 1 1
// Mixed traffic with more bursts
ffffffff26baca84 1 1 15 16 17 1 1 00 00 00 0 0
2418408208184085 3 1 01 02 03 0 0 01 02 03 1 1
2238c28212345678 2 0 00 00 00 0 0 05 06 07 1 0
242881802303ef04 3 1 1e 1f 20 1 0 03 04 05 0 0
0000000000000000 ff 0 00 00 00 0 0 00 00 00 0 0

// ==== list.f ====
hdl/quplsPkg.sv
hdl/quplsInstrStreamIf.sv
hdl/quplsFetchSplitter.sv
hdl/quplsInstrQueue.sv
hdl/quplsDecodeAluPair.sv
hdl/quplsDecodeStage.sv
hdl/quplsDecodeTop.sv
dv/quplsDecodeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode testbench with Verilator and runs it from the project root
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module quplsDecodeTb -o quplsDecodeSim \
	&& ./obj_dir/quplsDecodeSim 2>&1 | tee sim.log \
	|| { echo "Build or simulation failed"; exit 1; }
# The log decides the result
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"

// ==== dv/quplsDecodeTb.sv ====
module quplsDecodeTb;

	timeunit 1ns;
	timeprecision 100ps;

	// Each record in the input file spans this many words, one per column
	localparam int REC_WORDS = 13;
	localparam int MAX_RECS = 64;
	localparam int RESET_CYCLES = 8;
	// Slot 0 on an idle path passes a push cycle, a pop cycle and the output register
	localparam int IDLE_LATENCY = 2;

	// One expected decode result as queued in DUT output order
	typedef struct packed {
		quplsPkg::instruction_t instr;
		quplsPkg::regSpec_t rt;
		quplsPkg::regSpec_t ra;
		quplsPkg::regSpec_t rb;
		bit mul;
		bit pair;
		bit idle;
		int acceptCycle;
	} expEntry_t;

	logic clk;
	logic rstN;
	logic fetchValid;
	quplsPkg::fetchWord_t fetchWord;
	logic [1:0] slotMask;
	logic decodeStall = 1'b0;
	logic fetchStall;
	logic decodeValid;
	quplsPkg::instruction_t decodeInstr;
	quplsPkg::regSpec_t decodeRt;
	quplsPkg::regSpec_t decodeRa;
	quplsPkg::regSpec_t decodeRb;
	logic decodeMul;
	logic decodeAluPair;

	logic [63:0] stim [0:MAX_RECS*REC_WORDS-1];
	expEntry_t expQ [$];
	expEntry_t popped;
	expEntry_t pushed;
	int numRecs;
	int curRec;
	int base;
	int cycle = 0;
	int stallEnd = 0;
	int burst;
	integer seed = 46;
	bit loaded = 1'b0;
	bit started = 1'b0;
	bit idleNow;
	bit stallPrev = 1'b0;
	bit fetchStallPrev = 1'b0;
	bit sawFull = 1'b0;
	bit stallSeen = 1'b0;

	quplsDecodeTop UUT (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchWord(fetchWord),
		.slotMask(slotMask),
		.decodeStall(decodeStall),
		.fetchStall(fetchStall),
		.decodeValid(decodeValid),
		.decodeInstr(decodeInstr),
		.decodeRt(decodeRt),
		.decodeRa(decodeRa),
		.decodeRb(decodeRb),
		.decodeMul(decodeMul),
		.decodeAluPair(decodeAluPair)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Failure reporting
	// ====================

	task automatic abortRun();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkInstr(input string name, input quplsPkg::instruction_t expected,
		input quplsPkg::instruction_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0d ns: %s expected %h, got %h",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkReg(input string name, input quplsPkg::regSpec_t expected,
		input quplsPkg::regSpec_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input bit expected, input bit actual);
		if (actual != expected)
		begin
			$display("CHECK FAILED at %0d ns: %s expected %b, got %b",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	// Holds one record on the fetch port until an edge takes it
	task automatic offerRecord(input int rec);
		int b;
		b = rec * REC_WORDS;
		curRec = rec;
		fetchValid <= 1'b1;
		fetchWord <= stim[b];
		slotMask <= stim[b + 1][1:0];
		@(negedge clk);
		// fetchStall is a flop level, so it is settled at the falling edge
		while (fetchStall)
			@(negedge clk);
		@(posedge clk);
	endtask

	// Cycle count and the decode stall that stays high until stallEnd is reached
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		decodeStall <= (cycle < stallEnd);
	end

	initial
	begin
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchWord = '0;
		slotMask = 2'b00;
		$readmemh("dv/decodeInput.txt", stim);
		// The record list ends at the first mask of ff
		numRecs = 0;
		while (numRecs < MAX_RECS && stim[numRecs*REC_WORDS + 1][7:0] != 8'hff)
			numRecs++;
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		started = 1'b1;
		for (int r = 0; r < numRecs; r++)
			offerRecord(r);
		fetchValid <= 1'b0;
		slotMask <= 2'b00;
		while (expQ.size() != 0)
			@(posedge clk);
		// A few quiet cycles would expose a duplicated instruction
		repeat (4) @(posedge clk);
		if (stallSeen && !sawFull)
		begin
			$display("ERROR: the instruction queue never filled while decode was stalled");
			abortRun();
		end
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// Budget of 40 cycles per record on top of reset
	initial
	begin
		wait (loaded);
		repeat (numRecs * 40 + RESET_CYCLES + 4) @(posedge clk);
		$display("ERROR: decode output stopped arriving, %0d instructions outstanding",
			expQ.size());
		abortRun();
	end

	// ====================
	// Monitor
	// ====================

	// Everything is sampled at the falling edge half a cycle away from any drive
	always @(negedge clk)
	begin
		// Idle outputs in reset and before the first fetch
		if (!rstN || !started)
		begin
			checkFlag("decodeValid", 1'b0, decodeValid);
			checkFlag("decodeMul", 1'b0, decodeMul);
			checkFlag("decodeAluPair", 1'b0, decodeAluPair);
			checkFlag("fetchStall", 1'b0, fetchStall);
		end
		// Flags only ever travel with a valid pulse
		if (!decodeValid)
		begin
			checkFlag("decodeMul", 1'b0, decodeMul);
			checkFlag("decodeAluPair", 1'b0, decodeAluPair);
		end
		// A stall through the whole previous cycle blocks the pop behind this pulse
		if (stallPrev)
			checkFlag("decodeValid under decodeStall", 1'b0, decodeValid);
		if (decodeValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("ERROR: decodeValid pulsed with no instruction outstanding");
				abortRun();
			end
			popped = expQ.pop_front();
			checkInstr("decodeInstr", popped.instr, decodeInstr);
			checkReg("decodeRt", popped.rt, decodeRt);
			checkReg("decodeRa", popped.ra, decodeRa);
			checkReg("decodeRb", popped.rb, decodeRb);
			checkFlag("decodeMul", popped.mul, decodeMul);
			checkFlag("decodeAluPair", popped.pair, decodeAluPair);
			if (popped.idle && cycle - popped.acceptCycle != IDLE_LATENCY)
			begin
				$display("CHECK FAILED at %0d ns: decode latency expected %0d, got %0d",
					$time, IDLE_LATENCY, cycle - popped.acceptCycle);
				abortRun();
			end
		end
		// A held slot stalls fetch for one cycle only, so two in a row mean full
		if (fetchStall && fetchStallPrev)
			sawFull = 1'b1;
		fetchStallPrev = fetchStall;
		stallPrev = decodeStall;
		// The coming edge takes the word on the fetch port
		if (rstN && fetchValid && !fetchStall)
		begin
			base = curRec * REC_WORDS;
			idleNow = (expQ.size() == 0) && (stallEnd <= cycle) && !stim[base + 2][0];
			if (slotMask[0])
			begin
				pushed.instr = fetchWord.slot0;
				pushed.rt = stim[base + 3][5:0];
				pushed.ra = stim[base + 4][5:0];
				pushed.rb = stim[base + 5][5:0];
				pushed.mul = stim[base + 6][0];
				pushed.pair = stim[base + 7][0];
				pushed.idle = idleNow;
				pushed.acceptCycle = cycle;
				expQ.push_back(pushed);
			end
			if (slotMask[1])
			begin
				pushed.instr = fetchWord.slot1;
				pushed.rt = stim[base + 8][5:0];
				pushed.ra = stim[base + 9][5:0];
				pushed.rb = stim[base + 10][5:0];
				pushed.mul = stim[base + 11][0];
				pushed.pair = stim[base + 12][0];
				// A lone slot 1 is pushed in the accept cycle just like slot 0
				pushed.idle = idleNow && !slotMask[0];
				pushed.acceptCycle = cycle;
				expQ.push_back(pushed);
			end
			// Stall burst starts in the cycle after the accept edge
			if (stim[base + 2][0])
			begin
				stallSeen = 1'b1;
				burst = 12 + ({$random(seed)} % 16);
				if (cycle + 1 + burst > stallEnd)
					stallEnd = cycle + 1 + burst;
			end
		end
	end

endmodule

// ==== hdl/quplsDecodeTop.sv ====
module quplsDecodeTop (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input quplsPkg::fetchWord_t fetchWord,
	input logic [1:0] slotMask,
	input logic decodeStall,
	output logic fetchStall,
	output logic decodeValid,
	output quplsPkg::instruction_t decodeInstr,
	output quplsPkg::regSpec_t decodeRt,
	output quplsPkg::regSpec_t decodeRa,
	output quplsPkg::regSpec_t decodeRb,
	output logic decodeMul,
	output logic decodeAluPair
);

	// ====================
	// Instruction stream
	// ====================

	// Push side from the splitter, pop side into decode
	quplsInstrStreamIf #(
		.payloadT(quplsPkg::instruction_t)
	) instrStream ();

	// Splits each two-slot fetch into single pushes
	quplsFetchSplitter fetchSplitter (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchWord(fetchWord),
		.slotMask(slotMask),
		.fetchStall(fetchStall),
		.stream(instrStream.producer)
	);

	// Buffers instructions between fetch and decode
	quplsInstrQueue #(
		.payloadT(quplsPkg::instruction_t)
	) instrQueue (
		.clk(clk),
		.rstN(rstN),
		.stream(instrStream.queue)
	);

	// ====================
	// Decode
	// ====================

	quplsDecodeStage decodeStage (
		.clk(clk),
		.rstN(rstN),
		.stream(instrStream.consumer),
		.decodeStall(decodeStall),
		.decodeValid(decodeValid),
		.decodeInstr(decodeInstr),
		.decodeRt(decodeRt),
		.decodeRa(decodeRa),
		.decodeRb(decodeRb),
		.decodeMul(decodeMul),
		.decodeAluPair(decodeAluPair)
	);

endmodule

// ==== hdl/quplsDecodeStage.sv ====
module quplsDecodeStage (
	input logic clk,
	input logic rstN,
	quplsInstrStreamIf.consumer stream,
	input logic decodeStall,
	output logic decodeValid,
	output quplsPkg::instruction_t decodeInstr,
	output quplsPkg::regSpec_t decodeRt,
	output quplsPkg::regSpec_t decodeRa,
	output quplsPkg::regSpec_t decodeRb,
	output logic decodeMul,
	output logic decodeAluPair
);

	// Head of the queue, decoded in the cycle it is popped
	quplsPkg::instruction_t headInstr;
	// Combinational class flags for the head entry
	logic isMul;
	logic isAluPair;

	assign headInstr = stream.popData;

	// ====================
	// Pop control
	// ====================

	// Drain one entry every cycle that has data and no stall
	assign stream.pop = ~stream.empty & ~decodeStall;

	// ====================
	// Class decode
	// ====================

	quplsDecodeAluPair aluPairDec (
		.instr(headInstr),
		.aluPair(isAluPair)
	);

	// Any multiply function under a register form, narrow or wide
	always_comb
	begin
		case (headInstr.func)
			quplsPkg::FN_MUL,
			quplsPkg::FN_MULU,
			quplsPkg::FN_MULW,
			quplsPkg::FN_MULUW:
				isMul = quplsPkg::isR3(headInstr.opcode);
			default:
				isMul = 1'b0;
		endcase
	end

	// ====================
	// Output registers
	// ====================

	// Valid and flags drop on any cycle without a pop, so a flag is only
	// ever seen together with decodeValid
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decodeValid <= 1'b0;
			decodeMul <= 1'b0;
			decodeAluPair <= 1'b0;
		end
		else
		begin
			decodeValid <= stream.pop;
			decodeMul <= stream.pop & isMul;
			decodeAluPair <= stream.pop & isAluPair;
		end
	end

	// Instruction and register fields hold their last value between pops
	always_ff @(posedge clk)
	begin
		if (stream.pop)
		begin
			decodeInstr <= headInstr;
			decodeRt <= headInstr.rt;
			decodeRa <= headInstr.ra;
			decodeRb <= headInstr.rb;
		end
	end

endmodule

// ==== hdl/quplsDecodeAluPair.sv ====
module quplsDecodeAluPair (
	input quplsPkg::instruction_t instr,
	output logic aluPair
);

	// A wide multiply produces a double width result and occupies both ALUs
	// Only the register forms can carry it, any other opcode reads as plain
	function automatic logic fnIsAluPair(quplsPkg::instruction_t ir);
		logic wideMul;
		case (ir.func)
			quplsPkg::FN_MULW,
			quplsPkg::FN_MULUW:
				wideMul = 1'b1;
			default:
				wideMul = 1'b0;
		endcase
		// Func bits mean something else outside the r3 forms
		fnIsAluPair = quplsPkg::isR3(ir.opcode) & wideMul;
	endfunction

	assign aluPair = fnIsAluPair(instr);

endmodule

// ==== hdl/quplsInstrQueue.sv ====
module quplsInstrQueue #(
	parameter type payloadT = quplsPkg::instruction_t
) (
	input logic clk,
	input logic rstN,
	quplsInstrStreamIf.queue stream
);

	// Entry storage, never cleared
	payloadT mem [quplsPkg::QUEUE_DEPTH];

	logic [quplsPkg::QUEUE_PTR_W-1:0] wrPtr;
	logic [quplsPkg::QUEUE_PTR_W-1:0] rdPtr;
	// One bit wider than the pointers so a full queue can be told apart
	logic [quplsPkg::QUEUE_PTR_W:0] count;

	// Qualified strobes, a request against the wrong level is dropped
	logic pushOk;
	logic popOk;

	// ====================
	// Levels
	// ====================

	assign stream.full = (count == (quplsPkg::QUEUE_PTR_W + 1)'(quplsPkg::QUEUE_DEPTH));
	assign stream.empty = (count == '0);

	assign pushOk = stream.push & ~stream.full;
	assign popOk = stream.pop & ~stream.empty;

	// The head entry is shown in the same cycle it is popped
	assign stream.popData = mem[rdPtr];

	// ====================
	// Pointers and count
	// ====================

	// The depth is a power of two, so the pointers wrap by overflow
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1;
			if (popOk)
				rdPtr <= rdPtr + 1'b1;
			// Simultaneous push and pop leave the count alone
			case ({pushOk, popOk})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Write port, the new entry is readable from the next cycle
	always_ff @(posedge clk)
	begin
		if (pushOk)
			mem[wrPtr] <= stream.pushData;
	end

endmodule

// ==== hdl/quplsFetchSplitter.sv ====
module quplsFetchSplitter (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input quplsPkg::fetchWord_t fetchWord,
	input logic [1:0] slotMask,
	output logic fetchStall,
	quplsInstrStreamIf.producer stream
);

	// Set while slot 1 of an accepted word still waits for a push
	logic pending;
	// Copy of slot 1 taken at the accept edge
	quplsPkg::instruction_t holdSlot;
	// A fetch word is taken on this cycle's edge
	logic accept;
	// Both slots valid, so slot 1 has to wait one push
	logic bothSlots;

	// ====================
	// Fetch acceptance
	// ====================

	// Hold off fetch while the held slot is outstanding or the queue is full
	assign fetchStall = pending | stream.full;
	assign accept = fetchValid & ~fetchStall;
	assign bothSlots = slotMask[0] & slotMask[1];

	// ====================
	// Push generation
	// ====================

	// The held slot has priority. While it is pending no new word is accepted,
	// so the two push sources never compete
	always_comb
	begin
		if (pending)
		begin
			stream.push = ~stream.full;
			stream.pushData = holdSlot;
		end
		else
		begin
			// A mask of zero is accepted and pushes nothing
			stream.push = accept & (|slotMask);
			// Slot 0 goes first when valid, otherwise a lone slot 1 goes now
			stream.pushData = slotMask[0] ? fetchWord.slot0 : fetchWord.slot1;
		end
	end

	// Pending bit, cleared once the held slot finds room in the queue
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			pending <= 1'b0;
		else if (pending && !stream.full)
			pending <= 1'b0;
		else if (accept && bothSlots)
			pending <= 1'b1;
	end

	// Holding register is payload only
	always_ff @(posedge clk)
	begin
		if (accept && bothSlots)
			holdSlot <= fetchWord.slot1;
	end

endmodule

// ==== hdl/quplsInstrStreamIf.sv ====
interface quplsInstrStreamIf #(
	parameter type payloadT = quplsPkg::instruction_t
);

	// Producer side, a push is only raised while full is low
	logic push;
	payloadT pushData;
	logic full;

	// Consumer side, popData shows the head entry whenever empty is low
	logic pop;
	payloadT popData;
	logic empty;

	// Fetch splitter writes single instructions
	modport producer (
		output push, pushData,
		input full
	);

	// The FIFO owns the levels and the head entry
	modport queue (
		input push, pushData, pop,
		output full, popData, empty
	);

	// Decode stage drains the FIFO
	modport consumer (
		output pop,
		input popData, empty
	);

endinterface

// ==== hdl/quplsPkg.sv ====
package quplsPkg;

	// ====================
	// Queue sizing
	// ====================

	// Entries in the instruction queue between the splitter and decode
	localparam int unsigned QUEUE_DEPTH = 8;
	// Pointer width for the queue, log2 of the depth
	localparam int unsigned QUEUE_PTR_W = 3;

	// ====================
	// Instruction format
	// ====================

	// Architectural register number, 64 registers
	typedef logic [5:0] regSpec_t;

	// Major opcodes in the low seven bits of every instruction
	// Only the register forms and the no-op are decoded in this stage
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_R3B = 7'h02,
		OP_R3W = 7'h03,
		OP_R3T = 7'h04,
		OP_R3O = 7'h05
	} opcode_t;

	// Function codes in the top seven bits of an r3 instruction
	typedef enum logic [6:0] {
		FN_ADD = 7'h04,
		FN_SUB = 7'h05,
		FN_MUL = 7'h10,
		FN_MULU = 7'h11,
		FN_MULW = 7'h12,
		FN_MULUW = 7'h13
	} func_t;

	// Register format, listed from the high bits down
	// The opcode sits at bits 6:0 and func at bits 31:25
	typedef struct packed {
		func_t func;
		regSpec_t rb;
		regSpec_t ra;
		regSpec_t rt;
		opcode_t opcode;
	} instruction_t;

	// One fetch carries two instructions, slot 0 in the low half
	typedef struct packed {
		instruction_t slot1;
		instruction_t slot0;
	} fetchWord_t;

	// ====================
	// Decode helpers
	// ====================

	// True for the four register forms (byte, wyde, tetra, octa)
	// Both the multiply flag and the ALU-pair flag start from this test
	function automatic logic isR3(opcode_t op);
		case (op)
			OP_R3B, OP_R3W, OP_R3T, OP_R3O:
				isR3 = 1'b1;
			default:
				isR3 = 1'b0;
		endcase
	endfunction

endpackage
